//--- src/agq_pkg.sv
package agq_pkg;

    localparam int PAYLOAD_W = 8;
    localparam int AGE_W     = 4;
    localparam int CMD_W     = PAYLOAD_W + AGE_W;
    localparam int POS_W     = CMD_W - AGE_W;  // Retag position shares the payload bits

    localparam logic [AGE_W-1:0] AGE_MAX = '1;  // Aging saturates here

    typedef enum logic {
        OP_PUSH  = 1'b0,
        OP_RETAG = 1'b1
    } cmd_op_e;

    // One command word, read according to the opcode that travels with it
    typedef union packed {
        struct packed {
            logic [PAYLOAD_W-1:0] payload;
            logic [AGE_W-1:0]     age;
        } push_v;
        struct packed {
            logic [POS_W-1:0]     pos;  // Offset from the head entry
            logic [AGE_W-1:0]     age;
        } retag_v;
    } cmd_word_u;

endpackage

//--- src/tag_queue.sv
`timescale 1ns/1ps

module tag_queue
    import agq_pkg::*;
#(
    parameter int Q_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push_en,
    input  cmd_word_u                push_payload_age,
    input  logic                     pop_ready,
    input  logic [Q_DEPTH-1:0]       modify_mask,
    input  logic [Q_DEPTH*AGE_W-1:0] new_age_vector,
    output logic                     full,
    output logic                     out_valid,
    output logic [PAYLOAD_W-1:0]     out_payload,
    output logic [AGE_W-1:0]         out_age,
    output logic [Q_DEPTH-1:0]       head_onehot,
    output logic [Q_DEPTH-1:0]       occ_mask,
    output logic [Q_DEPTH*AGE_W-1:0] old_age_vector
);

    localparam logic [Q_DEPTH-1:0] PTR_INIT = {{(Q_DEPTH-1){1'b0}}, 1'b1};

    logic [PAYLOAD_W-1:0] payload_mem [Q_DEPTH];
    logic [AGE_W-1:0]     age_mem [Q_DEPTH];

    logic [Q_DEPTH-1:0]   wr_ptr;
    logic [Q_DEPTH-1:0]   rd_ptr;
    logic                 do_push;
    logic                 do_pop;
    logic [Q_DEPTH-1:0]   push_slot;
    logic [Q_DEPTH-1:0]   pop_slot;
    logic [Q_DEPTH-1:0]   age_wr;

    assign full        = &occ_mask;
    assign out_valid   = |occ_mask;
    assign head_onehot = rd_ptr;

    assign do_push   = push_en && !full;
    assign do_pop    = out_valid && pop_ready;
    assign push_slot = do_push ? wr_ptr : '0;
    assign pop_slot  = do_pop ? rd_ptr : '0;

    // A slot being written takes the push, so the modify only touches older entries
    assign age_wr = modify_mask & occ_mask & ~push_slot;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= PTR_INIT;
            rd_ptr   <= PTR_INIT;
            occ_mask <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= {wr_ptr[Q_DEPTH-2:0], wr_ptr[Q_DEPTH-1]};  // Rotate one-hot pointer
            end
            if (do_pop) begin
                rd_ptr <= {rd_ptr[Q_DEPTH-2:0], rd_ptr[Q_DEPTH-1]};
            end
            occ_mask <= (occ_mask & ~pop_slot) | push_slot;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < Q_DEPTH; i++) begin
            if (push_slot[i]) begin
                payload_mem[i] <= push_payload_age.push_v.payload;
                age_mem[i]     <= push_payload_age.push_v.age;
            end else if (age_wr[i]) begin
                age_mem[i] <= new_age_vector[i*AGE_W +: AGE_W];  // Payload stays put
            end
        end
    end

    // One-hot read mux for the head entry
    always_comb begin
        out_payload = '0;
        out_age     = '0;
        for (int i = 0; i < Q_DEPTH; i++) begin
            out_payload = out_payload | (payload_mem[i] & {PAYLOAD_W{rd_ptr[i]}});
            out_age     = out_age | (age_mem[i] & {AGE_W{rd_ptr[i]}});
        end
    end

    always_comb begin
        for (int i = 0; i < Q_DEPTH; i++) begin
            old_age_vector[i*AGE_W +: AGE_W] = age_mem[i];
        end
    end

endmodule

//--- src/command_decoder.sv
`timescale 1ns/1ps

module command_decoder
    import agq_pkg::*;
#(
    parameter int Q_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_valid,
    input  cmd_op_e                  cmd_op,
    input  cmd_word_u                cmd_word,
    input  logic                     full,
    input  logic [Q_DEPTH-1:0]       head_onehot,
    input  logic [Q_DEPTH-1:0]       occ_mask,
    input  logic                     retag_grant,
    output logic                     cmd_ready,
    output logic                     push_en,
    output cmd_word_u                push_payload_age,
    output logic                     retag_req,
    output logic [Q_DEPTH-1:0]       retag_mask,
    output logic [Q_DEPTH*AGE_W-1:0] retag_age_vector
);

    logic [2*Q_DEPTH-1:0]     head_pair;
    logic [Q_DEPTH-1:0]       target;
    logic                     pos_ok;
    logic                     retag_hit;
    logic [Q_DEPTH*AGE_W-1:0] lane_ages;

    // Retags have top priority at the arbiter, so they never wait
    assign cmd_ready        = (cmd_op == OP_PUSH) ? !full : 1'b1;
    assign push_en          = cmd_valid && cmd_ready && (cmd_op == OP_PUSH);
    assign push_payload_age = cmd_word;

    // Rotating the doubled head pointer left by pos lands on slot head+pos
    assign head_pair = {head_onehot, head_onehot} << cmd_word.retag_v.pos;
    assign target    = head_pair[2*Q_DEPTH-1:Q_DEPTH];
    assign pos_ok    = cmd_word.retag_v.pos < Q_DEPTH;

    // Occupied slots run contiguously from the head, so this is pos < count
    assign retag_hit = cmd_valid && cmd_ready && (cmd_op == OP_RETAG) && pos_ok
                       && |(target & occ_mask);

    always_comb begin
        for (int i = 0; i < Q_DEPTH; i++) begin
            lane_ages[i*AGE_W +: AGE_W] = target[i] ? cmd_word.retag_v.age : '0;
        end
    end

    assign retag_req        = retag_hit;
    assign retag_mask       = retag_hit ? target : '0;
    assign retag_age_vector = lane_ages;

endmodule

//--- src/age_engine.sv
`timescale 1ns/1ps

module age_engine
    import agq_pkg::*;
#(
    parameter int Q_DEPTH    = 8,
    parameter int AGE_PERIOD = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     age_en,
    input  logic [Q_DEPTH-1:0]       occ_mask,
    input  logic [Q_DEPTH*AGE_W-1:0] old_age_vector,
    input  logic                     age_grant,
    output logic                     age_req,
    output logic [Q_DEPTH-1:0]       age_mask,
    output logic [Q_DEPTH*AGE_W-1:0] age_vector
);

    localparam int CNT_W = (AGE_PERIOD > 1) ? $clog2(AGE_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(AGE_PERIOD - 1);

    logic [CNT_W-1:0] period_cnt;
    logic             wrap;
    logic             tick_pend;

    assign wrap    = age_en && (period_cnt == CNT_LAST);
    assign age_req = wrap || tick_pend;  // The wrap cycle itself may already be granted

    // Sampled at the grant edge, so entries pushed earlier in the wait are included
    assign age_mask = age_req ? occ_mask : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            period_cnt <= '0;
            tick_pend  <= 1'b0;
        end else begin
            if (age_en) begin
                period_cnt <= wrap ? '0 : period_cnt + 1'b1;
            end
            tick_pend <= age_req && !age_grant;
        end
    end

    always_comb begin
        logic [AGE_W-1:0] lane_old;
        for (int i = 0; i < Q_DEPTH; i++) begin
            lane_old = old_age_vector[i*AGE_W +: AGE_W];
            if (lane_old == AGE_MAX) begin
                age_vector[i*AGE_W +: AGE_W] = AGE_MAX;
            end else begin
                age_vector[i*AGE_W +: AGE_W] = lane_old + 1'b1;
            end
        end
    end

endmodule

//--- src/modify_arbiter.sv
`timescale 1ns/1ps

module modify_arbiter
    import agq_pkg::*;
#(
    parameter int Q_DEPTH = 8
) (
    input  logic                     retag_req,
    input  logic [Q_DEPTH-1:0]       retag_mask,
    input  logic [Q_DEPTH*AGE_W-1:0] retag_age_vector,
    input  logic                     age_req,
    input  logic [Q_DEPTH-1:0]       age_mask,
    input  logic [Q_DEPTH*AGE_W-1:0] age_vector,
    output logic                     retag_grant,
    output logic                     age_grant,
    output logic [Q_DEPTH-1:0]       modify_mask,
    output logic [Q_DEPTH*AGE_W-1:0] new_age_vector
);

    // Retag always wins, the aging tick waits behind it
    assign retag_grant = retag_req;
    assign age_grant   = age_req && !retag_req;

    always_comb begin
        if (retag_grant) begin
            modify_mask    = retag_mask;
            new_age_vector = retag_age_vector;
        end else if (age_grant) begin
            modify_mask    = age_mask;
            new_age_vector = age_vector;
        end else begin
            modify_mask    = '0;  // Idle port leaves every slot alone
            new_age_vector = '0;
        end
    end

endmodule

//--- src/agq_top.sv
`timescale 1ns/1ps

module agq_top
    import agq_pkg::*;
#(
    parameter int Q_DEPTH    = 8,
    parameter int AGE_PERIOD = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  cmd_op_e              cmd_op,
    input  cmd_word_u            cmd_word,
    input  logic                 age_en,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [PAYLOAD_W-1:0] out_payload,
    output logic [AGE_W-1:0]     out_age
);

    logic                     push_en;
    cmd_word_u                push_payload_age;
    logic                     full;
    logic [Q_DEPTH-1:0]       head_onehot;
    logic [Q_DEPTH-1:0]       occ_mask;
    logic [Q_DEPTH*AGE_W-1:0] old_age_vector;

    logic                     retag_req;
    logic                     retag_grant;
    logic [Q_DEPTH-1:0]       retag_mask;
    logic [Q_DEPTH*AGE_W-1:0] retag_age_vector;

    logic                     age_req;
    logic                     age_grant;
    logic [Q_DEPTH-1:0]       age_mask;
    logic [Q_DEPTH*AGE_W-1:0] age_vector;

    logic [Q_DEPTH-1:0]       modify_mask;
    logic [Q_DEPTH*AGE_W-1:0] new_age_vector;

    tag_queue #(.Q_DEPTH(Q_DEPTH)) u_queue (
        .clk              (clk),
        .rst              (rst),
        .push_en          (push_en),
        .push_payload_age (push_payload_age),
        .pop_ready        (out_ready),
        .modify_mask      (modify_mask),
        .new_age_vector   (new_age_vector),
        .full             (full),
        .out_valid        (out_valid),
        .out_payload      (out_payload),
        .out_age          (out_age),
        .head_onehot      (head_onehot),
        .occ_mask         (occ_mask),
        .old_age_vector   (old_age_vector)
    );

    command_decoder #(.Q_DEPTH(Q_DEPTH)) u_decoder (
        .clk              (clk),
        .rst              (rst),
        .cmd_valid        (cmd_valid),
        .cmd_op           (cmd_op),
        .cmd_word         (cmd_word),
        .full             (full),
        .head_onehot      (head_onehot),
        .occ_mask         (occ_mask),
        .retag_grant      (retag_grant),
        .cmd_ready        (cmd_ready),
        .push_en          (push_en),
        .push_payload_age (push_payload_age),
        .retag_req        (retag_req),
        .retag_mask       (retag_mask),
        .retag_age_vector (retag_age_vector)
    );

    age_engine #(.Q_DEPTH(Q_DEPTH), .AGE_PERIOD(AGE_PERIOD)) u_aging (
        .clk              (clk),
        .rst              (rst),
        .age_en           (age_en),
        .occ_mask         (occ_mask),
        .old_age_vector   (old_age_vector),
        .age_grant        (age_grant),
        .age_req          (age_req),
        .age_mask         (age_mask),
        .age_vector       (age_vector)
    );

    modify_arbiter #(.Q_DEPTH(Q_DEPTH)) u_arbiter (
        .retag_req        (retag_req),
        .retag_mask       (retag_mask),
        .retag_age_vector (retag_age_vector),
        .age_req          (age_req),
        .age_mask         (age_mask),
        .age_vector       (age_vector),
        .retag_grant      (retag_grant),
        .age_grant        (age_grant),
        .modify_mask      (modify_mask),
        .new_age_vector   (new_age_vector)
    );

endmodule

//--- bench/agq_properties.sv
`timescale 1ns/1ps

module agq_properties
    import agq_pkg::*;
#(
    parameter int Q_DEPTH = 8
) (
    input logic               clk,
    input logic               rst,
    input logic               cmd_valid,
    input logic               cmd_ready,
    input cmd_op_e            cmd_op,
    input logic               retag_grant,
    input logic               age_grant,
    input logic [Q_DEPTH-1:0] modify_mask,
    input logic [Q_DEPTH-1:0] occ_mask,
    input logic               out_valid,
    input logic               out_ready
);

    int violations = 0;  // Failed assertions so far
    int entry_count;     // Entries held, counted from the push and pop handshakes

    always @(posedge clk) begin
        if (rst) begin
            entry_count <= 0;
        end else begin
            entry_count <= entry_count + int'(cmd_valid && cmd_ready && cmd_op == OP_PUSH)
                           - int'(out_valid && out_ready);
        end
    end

    grants_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(retag_grant && age_grant))
        else begin
            $error("Retag and aging grants are high in the same cycle");
            violations++;
        end

    modify_inside_occupied: assert property (@(posedge clk) disable iff (rst)
        (modify_mask & ~occ_mask) == '0)
        else begin
            $error("Modify mask touches a slot that holds no entry");
            violations++;
        end

    empty_means_not_valid: assert property (@(posedge clk) disable iff (rst)
        (entry_count == 0) |-> !out_valid)
        else begin
            $error("Output is valid while the queue is empty");
            violations++;
        end

endmodule

// The arbiter grants and the queue occupancy meet as nets in the top level
bind agq_top agq_properties #(.Q_DEPTH(Q_DEPTH)) u_props (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_op      (cmd_op),
    .retag_grant (retag_grant),
    .age_grant   (age_grant),
    .modify_mask (modify_mask),
    .occ_mask    (occ_mask),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
);

//--- bench/agq_tb.sv
`timescale 1ns/1ps

module agq_tb
    import agq_pkg::*;
();

    localparam int Q_DEPTH    = 8;
    localparam int AGE_PERIOD = 16;
    localparam int AGE_STEPS  = 3;
    localparam int MAX_CYCLES = 4000;  // The five tests need about 400 cycles

    logic                 clk;
    logic                 rst;
    logic                 cmd_valid;
    logic                 cmd_ready;
    cmd_op_e              cmd_op;
    cmd_word_u            cmd_word;
    logic                 age_en;
    logic                 out_valid;
    logic                 out_ready;
    logic [PAYLOAD_W-1:0] out_payload;
    logic [AGE_W-1:0]     out_age;

    logic [CMD_W-1:0] model_q [$];  // Payload above age, head first
    int               seed = 63132;
    int               error_count;
    int               check_count;
    int               tick_count;
    int               ticks_before;
    int               cycle_count;
    string            test_name;

    agq_top #(.Q_DEPTH(Q_DEPTH), .AGE_PERIOD(AGE_PERIOD)) DUT (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_op      (cmd_op),
        .cmd_word    (cmd_word),
        .age_en      (age_en),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (out_payload),
        .out_age     (out_age)
    );

    always #5 clk = ~clk;

    function automatic logic [AGE_W-1:0] aged(input logic [AGE_W-1:0] age);
        if (age == {AGE_W{1'b1}}) begin
            return age;  // Already at the ceiling
        end
        return age + 1'b1;
    endfunction

    // Position counts from the head, anything at or past the tail is ignored
    function automatic int retag_index(input int pos, input int count);
        return (pos < count) ? pos : -1;
    endfunction

    function automatic logic [CMD_W-1:0] pop_entry();
        return model_q.pop_front();
    endfunction

    function automatic logic [31:0] rand_below(input int limit);
        logic [31:0] r;
        r = $random(seed);
        return r % limit;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        assert (expected == actual) else begin
            $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // Compares at each edge before the edge's handshakes enter the model
    always @(posedge clk) begin
        logic [CMD_W-1:0] head;
        int               idx;
        if (!rst) begin
            check_value("out_valid", model_q.size() != 0, out_valid);
            if (cmd_op == OP_PUSH) begin
                check_value("push cmd_ready", model_q.size() < Q_DEPTH, cmd_ready);
            end else begin
                check_value("retag cmd_ready", 1, cmd_ready);
            end
            if (out_valid && out_ready && model_q.size() != 0) begin
                head = model_q[0];
                check_value("payload", head[CMD_W-1:AGE_W], out_payload);
                check_value("age", head[AGE_W-1:0], out_age);
            end
            if (cmd_valid && cmd_ready && cmd_op == OP_RETAG) begin
                idx = retag_index(cmd_word.retag_v.pos, model_q.size());
                if (idx >= 0) begin
                    model_q[idx][AGE_W-1:0] = cmd_word.retag_v.age;
                end
            end
            if (DUT.age_grant) begin
                tick_count++;
                foreach (model_q[i]) begin
                    model_q[i][AGE_W-1:0] = aged(model_q[i][AGE_W-1:0]);
                end
            end
            if (out_valid && out_ready && model_q.size() != 0) begin
                void'(pop_entry());
            end
            if (cmd_valid && cmd_ready && cmd_op == OP_PUSH) begin
                model_q.push_back({cmd_word.push_v.payload, cmd_word.push_v.age});
            end
        end
    end

    // Called at a falling edge and returns at a falling edge
    task automatic send_cmd(input cmd_op_e op, input logic [7:0] upper, input logic [3:0] age);
        cmd_valid = 1'b1;
        cmd_op    = op;
        if (op == OP_PUSH) begin
            cmd_word.push_v.payload = upper;
            cmd_word.push_v.age     = age;
        end else begin
            cmd_word.retag_v.pos = upper;
            cmd_word.retag_v.age = age;
        end
        @(posedge clk);
        while (!cmd_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic drain(input logic random_ready);
        while (model_q.size() != 0) begin
            out_ready = random_ready ? rand_below(2) : 1'b1;
            @(negedge clk);
        end
        out_ready = 1'b0;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks: %0d  Errors: %0d", check_count, error_count + 1);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = OP_PUSH;
        cmd_word     = '0;
        age_en       = 1'b0;
        out_ready    = 1'b0;
        error_count  = 0;
        check_count  = 0;
        tick_count   = 0;
        test_name    = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "fifo_order";
        for (int n = 0; n < 40; n++) begin
            out_ready = rand_below(2);
            if (model_q.size() < Q_DEPTH) begin
                send_cmd(OP_PUSH, rand_below(256), rand_below(16));
            end else begin
                out_ready = 1'b1;  // Full, so let one entry leave
                @(negedge clk);
            end
        end
        drain(1'b1);

        test_name = "full_stall";
        repeat (Q_DEPTH) send_cmd(OP_PUSH, rand_below(256), rand_below(16));
        cmd_valid = 1'b1;
        cmd_op    = OP_PUSH;
        cmd_word  = {8'hEE, 4'h5};
        repeat (4) begin
            @(posedge clk);
            check_value("stalled cmd_ready", 0, cmd_ready);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        check_value("entries held", Q_DEPTH, model_q.size());
        drain(1'b0);

        test_name = "retag";
        repeat (5) send_cmd(OP_PUSH, rand_below(256), rand_below(16));
        send_cmd(OP_RETAG, 8'd2, 4'hA);
        send_cmd(OP_RETAG, 8'd0, 4'h3);
        check_value("head age", 4'h3, out_age);
        send_cmd(OP_RETAG, 8'd5, 4'hF);  // Equal to the count
        send_cmd(OP_RETAG, 8'd200, 4'h1);
        drain(1'b0);

        test_name = "aging";
        send_cmd(OP_PUSH, rand_below(256), 4'd14);  // Saturates on the second tick
        repeat (5) send_cmd(OP_PUSH, rand_below(256), rand_below(16));
        ticks_before = tick_count;
        age_en = 1'b1;
        repeat (AGE_STEPS * AGE_PERIOD) @(negedge clk);
        age_en = 1'b0;
        check_value("tick count", AGE_STEPS, tick_count - ticks_before);
        repeat (2 * AGE_PERIOD) @(negedge clk);
        check_value("ticks with age_en low", AGE_STEPS, tick_count - ticks_before);
        drain(1'b0);

        test_name = "contention";
        repeat (4) send_cmd(OP_PUSH, rand_below(256), rand_below(16));
        ticks_before = tick_count;
        age_en = 1'b1;
        for (int n = 0; n < AGE_PERIOD + 4; n++) begin
            if (n == AGE_PERIOD) begin
                age_en = 1'b0;
            end
            send_cmd(OP_RETAG, rand_below(model_q.size()), rand_below(16));
        end
        check_value("tick held behind retags", 0, tick_count - ticks_before);
        repeat (2) @(negedge clk);
        check_value("tick applied after retags", 1, tick_count - ticks_before);
        drain(1'b1);

        repeat (2) @(negedge clk);
        error_count += DUT.u_props.violations;
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- agq_top.f
src/agq_pkg.sv
src/tag_queue.sv
src/command_decoder.sv
src/age_engine.sv
src/modify_arbiter.sv
src/agq_top.sv
bench/agq_properties.sv
bench/agq_tb.sv
